/* dequant_engine.sv */
`include "qdq_mlsu_cfg.svh"

module dequant_engine (
  input  logic                clk,
  input  logic                rstnn,
  input  logic                dq_go_i,
  input  qdq_pkg::dqsh_t      dq_shift_i,
  output logic                dq_idle_o,
  output logic                rd_en_o,
  output qdq_pkg::spad_addr_t rd_addr_o,
  input  logic                rd_valid_i,
  input  qdq_pkg::spad_word_t rd_data_i,
  output logic                o_row_valid_o,
  output logic                o_row_last_o,
  output qdq_pkg::out_row_t   o_row_data_o,
  input  logic                o_row_ready_i
);
  import qdq_pkg::*;

  typedef enum logic [1:0] {DQ_IDLE, DQ_EXEC, DQ_STORE} dq_state_t;

  localparam row_idx_t ROWS_IDX = row_idx_t'(`QDQ_ROWS);
  localparam row_idx_t LAST_IDX = row_idx_t'(`QDQ_ROWS - 1);

  dq_state_t state_q;
  dqsh_t     shift_q;
  row_idx_t  issued_q;
  row_idx_t  sent_q;
  logic      rq_in_ready;
  logic      rq_out_valid;
  out_row_t  rq_out_data;
  row_idx_t  obuf_count;
  logic      obuf_full;
  logic      obuf_rd;

  assign dq_idle_o = (state_q == DQ_IDLE);

  // Accumulator reads, one per accepted requantizer slot
  assign rd_en_o   = (state_q == DQ_EXEC) && (issued_q != ROWS_IDX) && rq_in_ready;
  assign rd_addr_o = spad_addr_t'(`QDQ_ACC_BASE) + spad_addr_t'(issued_q);

  row_requantizer #(
    .LANES(`QDQ_ROWS), .IN_W(`QDQ_ACC_W), .OUT_W(`QDQ_OUT_W),
    .in_row_t(acc_row_t), .out_row_t(out_row_t)
  ) u_rq_o (
    .clk(clk), .rstnn(rstnn), .shift_i(shift_q),
    .in_valid_i(rd_valid_i), .in_ready_o(rq_in_ready), .in_data_i(acc_row_t'(rd_data_i)),
    .out_valid_o(rq_out_valid), .out_ready_i(!obuf_full), .out_data_o(rq_out_data)
  );

  row_buffer #(
    .row_t(out_row_t), .DEPTH(`QDQ_ROWS)
  ) u_obuf (
    .clk(clk), .rstnn(rstnn),
    .wr_en_i(rq_out_valid), .wr_data_i(rq_out_data),
    .rd_en_i(obuf_rd), .rd_data_o(o_row_data_o),
    .count_o(obuf_count), .full_o(obuf_full)
  );

  // ==============================
  // Output row stream
  // ==============================
  assign o_row_valid_o = (state_q == DQ_STORE) && (obuf_count != '0);
  assign o_row_last_o  = o_row_valid_o && (sent_q == LAST_IDX);
  assign obuf_rd       = o_row_valid_o && o_row_ready_i;

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      state_q  <= DQ_IDLE;
      issued_q <= '0;
      sent_q   <= '0;
    end else begin
      case (state_q)
        DQ_IDLE: if (dq_go_i) begin
          state_q  <= DQ_EXEC;
          issued_q <= '0;
          sent_q   <= '0;
        end
        DQ_EXEC: begin
          if (rd_en_o) issued_q <= issued_q + 1'b1;
          // All rows collected once the buffer is full
          if (obuf_full) state_q <= DQ_STORE;
        end
        DQ_STORE: if (obuf_rd) begin
          sent_q <= sent_q + 1'b1;
          if (o_row_last_o) state_q <= DQ_IDLE;
        end
        default: state_q <= DQ_IDLE;
      endcase
    end
  end

  // Shift held for the whole operation
  always_ff @(posedge clk) begin
    if (dq_go_i && dq_idle_o) begin
      shift_q <= dq_shift_i;
    end
  end

endmodule

/* qdq_mlsu.f */
+incdir+.
qdq_pkg.sv
row_buffer.sv
row_requantizer.sv
scratchpad.sv
quant_engine.sv
dequant_engine.sv
qdq_mlsu_top.sv
qdq_mlsu_asserts.sv
tb_qdq_mlsu.sv

/* qdq_mlsu_asserts.sv */
module qdq_mlsu_asserts (
  input logic              clk,
  input logic              rstnn,
  input logic              out_valid_i,
  input logic              out_ready_i,
  input logic              out_last_i,
  input qdq_pkg::out_row_t out_data_i,
  input logic              ext_ren_i,
  input logic              ext_rvalid_i,
  input logic              q_finish_i
);

  int unsigned fail_count = 0;

  // Stalled output row holds its contents
  property hold_while_stalled;
    @(posedge clk) disable iff (!rstnn)
      (out_valid_i && !out_ready_i) |=>
        (out_valid_i && $stable(out_data_i) && $stable(out_last_i));
  endproperty

  property ext_read_latency;
    @(posedge clk) disable iff (!rstnn)
      ext_ren_i |=> ext_rvalid_i;
  endproperty

  property ext_no_stray_valid;
    @(posedge clk) disable iff (!rstnn)
      !ext_ren_i |=> !ext_rvalid_i;
  endproperty

  property finish_single_pulse;
    @(posedge clk) disable iff (!rstnn)
      q_finish_i |=> !q_finish_i;
  endproperty

  assert property (hold_while_stalled) else begin
    $error("Output row changed while stalled");
    fail_count++;
  end
  assert property (ext_read_latency) else begin
    $error("External read data not valid next cycle");
    fail_count++;
  end
  assert property (ext_no_stray_valid) else begin
    $error("External read valid without a read");
    fail_count++;
  end
  assert property (finish_single_pulse) else begin
    $error("q_finish_o high for two cycles");
    fail_count++;
  end

endmodule

bind qdq_mlsu_top qdq_mlsu_asserts u_asserts (
  .clk(clk),
  .rstnn(rstnn),
  .out_valid_i(o_row_valid_o),
  .out_ready_i(o_row_ready_i),
  .out_last_i(o_row_last_o),
  .out_data_i(o_row_data_o),
  .ext_ren_i(ext_ren_i),
  .ext_rvalid_i(ext_rvalid_o),
  .q_finish_i(q_finish_o)
);

/* qdq_mlsu_cfg.svh */
`ifndef QDQ_MLSU_CFG_SVH
`define QDQ_MLSU_CFG_SVH

// Matrix geometry, rows and columns are equal
`define QDQ_ROWS        4

// Lane widths per data type
`define QDQ_IN_W        16
`define QDQ_Q_W         8
`define QDQ_ACC_W       32
`define QDQ_OUT_W       16

// Scratchpad geometry and region bases
`define QDQ_SPAD_W      128
`define QDQ_SPAD_DEPTH  64
`define QDQ_QA_BASE     0
`define QDQ_QB_BASE     16
`define QDQ_ACC_BASE    32

// Instruction shift fields
`define QDQ_QSH_W       4
`define QDQ_DQSH_W      5

`endif

/* qdq_mlsu_top.sv */
`include "qdq_mlsu_cfg.svh"

module qdq_mlsu_top (
  input  logic                clk,
  input  logic                rstnn,
  input  logic                inst_fifo_rready_i,
  input  qdq_pkg::inst_t      inst_fifo_rdata_i,
  output logic                inst_fifo_rrequest_o,
  input  logic                x_row_valid_i,
  input  logic                x_row_last_i,
  input  qdq_pkg::in_row_t    x_row_data_i,
  output logic                x_row_ready_o,
  input  logic                w_row_valid_i,
  input  logic                w_row_last_i,
  input  qdq_pkg::in_row_t    w_row_data_i,
  output logic                w_row_ready_o,
  output logic                o_row_valid_o,
  output logic                o_row_last_o,
  output qdq_pkg::out_row_t   o_row_data_o,
  input  logic                o_row_ready_i,
  input  logic                ext_wen_i,
  input  logic                ext_ren_i,
  input  qdq_pkg::spad_addr_t ext_addr_i,
  input  qdq_pkg::spad_word_t ext_wdata_i,
  output logic                ext_rvalid_o,
  output qdq_pkg::spad_word_t ext_rdata_o,
  output logic                q_finish_o
);
  import qdq_pkg::*;

  row_idx_t   x_count, w_count;
  in_row_t    x_head, w_head;
  logic       x_rd_en, w_rd_en, x_full, w_full;
  logic       spad_wen, dq_go, dq_idle, dq_rd_en, dq_rd_valid;
  spad_addr_t spad_waddr, dq_rd_addr;
  spad_word_t spad_wdata, dq_rd_data;
  dqsh_t      dq_shift;

  // Row count bounds a matrix, so the last flags carry no extra information
  assign x_row_ready_o = !x_full;
  assign w_row_ready_o = !w_full;

  row_buffer #(.row_t(in_row_t), .DEPTH(`QDQ_ROWS)) u_xbuf (
    .clk(clk), .rstnn(rstnn), .wr_en_i(x_row_valid_i), .wr_data_i(x_row_data_i),
    .rd_en_i(x_rd_en), .rd_data_o(x_head), .count_o(x_count), .full_o(x_full)
  );

  row_buffer #(.row_t(in_row_t), .DEPTH(`QDQ_ROWS)) u_wbuf (
    .clk(clk), .rstnn(rstnn), .wr_en_i(w_row_valid_i), .wr_data_i(w_row_data_i),
    .rd_en_i(w_rd_en), .rd_data_o(w_head), .count_o(w_count), .full_o(w_full)
  );

  quant_engine u_quant (
    .clk(clk), .rstnn(rstnn),
    .inst_fifo_rready_i(inst_fifo_rready_i), .inst_fifo_rdata_i(inst_fifo_rdata_i),
    .inst_fifo_rrequest_o(inst_fifo_rrequest_o),
    .x_count_i(x_count), .w_count_i(w_count), .x_head_i(x_head), .w_head_i(w_head),
    .x_rd_en_o(x_rd_en), .w_rd_en_o(w_rd_en),
    .spad_wen_o(spad_wen), .spad_waddr_o(spad_waddr), .spad_wdata_o(spad_wdata),
    .dq_go_o(dq_go), .dq_shift_o(dq_shift), .dq_idle_i(dq_idle), .q_finish_o(q_finish_o)
  );

  dequant_engine u_dequant (
    .clk(clk), .rstnn(rstnn), .dq_go_i(dq_go), .dq_shift_i(dq_shift), .dq_idle_o(dq_idle),
    .rd_en_o(dq_rd_en), .rd_addr_o(dq_rd_addr), .rd_valid_i(dq_rd_valid),
    .rd_data_i(dq_rd_data), .o_row_valid_o(o_row_valid_o), .o_row_last_o(o_row_last_o),
    .o_row_data_o(o_row_data_o), .o_row_ready_i(o_row_ready_i)
  );

  scratchpad u_spad (
    .clk(clk), .rstnn(rstnn), .wen_i(spad_wen), .waddr_i(spad_waddr), .wdata_i(spad_wdata),
    .rd_en_i(dq_rd_en), .rd_addr_i(dq_rd_addr), .rd_valid_o(dq_rd_valid),
    .rd_data_o(dq_rd_data), .ext_wen_i(ext_wen_i), .ext_ren_i(ext_ren_i),
    .ext_addr_i(ext_addr_i), .ext_wdata_i(ext_wdata_i), .ext_rvalid_o(ext_rvalid_o),
    .ext_rdata_o(ext_rdata_o)
  );

endmodule

/* qdq_pkg.sv */
`include "qdq_mlsu_cfg.svh"

package qdq_pkg;

  // Row payloads
  typedef logic [`QDQ_ROWS*`QDQ_IN_W-1:0]  in_row_t;
  typedef logic [`QDQ_ROWS*`QDQ_Q_W-1:0]   q_row_t;
  typedef logic [`QDQ_ROWS*`QDQ_ACC_W-1:0] acc_row_t;
  typedef logic [`QDQ_ROWS*`QDQ_OUT_W-1:0] out_row_t;

  // Scratchpad word and address
  typedef logic [`QDQ_SPAD_W-1:0]             spad_word_t;
  typedef logic [$clog2(`QDQ_SPAD_DEPTH)-1:0] spad_addr_t;

  // Counts 0 to ROWS inclusive
  typedef logic [$clog2(`QDQ_ROWS+1)-1:0] row_idx_t;

  typedef logic [`QDQ_QSH_W-1:0]  qsh_t;
  typedef logic [`QDQ_DQSH_W-1:0] dqsh_t;

  // {q_start, dq_start, qsh, dqsh}, MSB first
  typedef logic [2+`QDQ_QSH_W+`QDQ_DQSH_W-1:0] inst_t;

endpackage

/* quant_engine.sv */
`include "qdq_mlsu_cfg.svh"

module quant_engine (
  input  logic                clk,
  input  logic                rstnn,
  input  logic                inst_fifo_rready_i,
  input  qdq_pkg::inst_t      inst_fifo_rdata_i,
  output logic                inst_fifo_rrequest_o,
  input  qdq_pkg::row_idx_t   x_count_i,
  input  qdq_pkg::row_idx_t   w_count_i,
  input  qdq_pkg::in_row_t    x_head_i,
  input  qdq_pkg::in_row_t    w_head_i,
  output logic                x_rd_en_o,
  output logic                w_rd_en_o,
  output logic                spad_wen_o,
  output qdq_pkg::spad_addr_t spad_waddr_o,
  output qdq_pkg::spad_word_t spad_wdata_o,
  output logic                dq_go_o,
  output qdq_pkg::dqsh_t      dq_shift_o,
  input  logic                dq_idle_i,
  output logic                q_finish_o
);
  import qdq_pkg::*;

  typedef enum logic [1:0] {Q_IDLE, Q_LOAD, Q_EXEC, Q_STORE} q_state_t;

  localparam row_idx_t ROWS_IDX = row_idx_t'(`QDQ_ROWS);

  q_state_t state_q;
  logic     have_inst, q_start_q, dq_start_q;
  qsh_t     qsh_q;
  dqsh_t    dqsh_q;
  logic     inst_q_start, inst_dq_start;
  qsh_t     inst_qsh;
  dqsh_t    inst_dqsh;
  logic     inst_fetch, go_exec, go_store, go_idle;
  row_idx_t a_sent, b_sent, qa_cnt, qb_cnt;
  logic     a_in_ready, b_in_ready, a_out_valid, b_out_valid;
  q_row_t   a_out_data, b_out_data, qa_buf, qb_buf;
  logic     qa_buf_valid, qb_buf_valid, rr_q, pick_qa, pick_qb;

  // ==============================
  // Instruction fetch and FSM
  // ==============================
  assign {inst_q_start, inst_dq_start, inst_qsh, inst_dqsh} = inst_fifo_rdata_i;
  assign inst_fifo_rrequest_o = (state_q == Q_IDLE) && !have_inst;
  assign inst_fetch = inst_fifo_rready_i && inst_fifo_rrequest_o;
  assign go_exec    = (state_q == Q_LOAD) && (x_count_i == ROWS_IDX) && (w_count_i == ROWS_IDX);
  assign go_store   = (state_q == Q_EXEC) && (qa_cnt == ROWS_IDX) && (qb_cnt == ROWS_IDX);
  assign go_idle    = (state_q == Q_STORE) && dq_idle_i;
  assign q_finish_o = go_store;
  assign dq_go_o    = go_idle && dq_start_q;
  assign dq_shift_o = dqsh_q;

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      state_q    <= Q_IDLE;
      have_inst  <= 1'b0;
      q_start_q  <= 1'b0;
      dq_start_q <= 1'b0;
    end else begin
      if (inst_fetch) begin
        have_inst  <= 1'b1;
        q_start_q  <= inst_q_start;
        dq_start_q <= inst_dq_start;
      end
      case (state_q)
        // Without quantize enable go straight to hand-off
        Q_IDLE:  if (have_inst) state_q <= q_start_q ? Q_LOAD : Q_STORE;
        Q_LOAD:  if (go_exec) state_q <= Q_EXEC;
        Q_EXEC:  if (go_store) state_q <= Q_STORE;
        Q_STORE: if (go_idle) begin
          state_q   <= Q_IDLE;
          have_inst <= 1'b0;
        end
        default: state_q <= Q_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (inst_fetch) begin
      qsh_q  <= inst_qsh;
      dqsh_q <= inst_dqsh;
    end
  end

  // ==============================
  // Buffer heads into requantizers
  // ==============================
  assign x_rd_en_o = (state_q == Q_EXEC) && (a_sent != ROWS_IDX) && a_in_ready;
  assign w_rd_en_o = (state_q == Q_EXEC) && (b_sent != ROWS_IDX) && b_in_ready;

  row_requantizer #(
    .LANES(`QDQ_ROWS), .IN_W(`QDQ_IN_W), .OUT_W(`QDQ_Q_W),
    .in_row_t(in_row_t), .out_row_t(q_row_t)
  ) u_rq_a (
    .clk(clk), .rstnn(rstnn), .shift_i(dqsh_t'(qsh_q)),
    .in_valid_i(x_rd_en_o), .in_ready_o(a_in_ready), .in_data_i(x_head_i),
    .out_valid_o(a_out_valid), .out_ready_i(!qa_buf_valid), .out_data_o(a_out_data)
  );

  row_requantizer #(
    .LANES(`QDQ_ROWS), .IN_W(`QDQ_IN_W), .OUT_W(`QDQ_Q_W),
    .in_row_t(in_row_t), .out_row_t(q_row_t)
  ) u_rq_b (
    .clk(clk), .rstnn(rstnn), .shift_i(dqsh_t'(qsh_q)),
    .in_valid_i(w_rd_en_o), .in_ready_o(b_in_ready), .in_data_i(w_head_i),
    .out_valid_o(b_out_valid), .out_ready_i(!qb_buf_valid), .out_data_o(b_out_data)
  );

  // ==============================
  // Skid registers, round-robin writes
  // ==============================
  assign pick_qa = qa_buf_valid && (!qb_buf_valid || rr_q);
  assign pick_qb = qb_buf_valid && (!qa_buf_valid || !rr_q);
  assign spad_wen_o   = pick_qa || pick_qb;
  assign spad_waddr_o = pick_qa ? spad_addr_t'(`QDQ_QA_BASE) + spad_addr_t'(qa_cnt)
                                : spad_addr_t'(`QDQ_QB_BASE) + spad_addr_t'(qb_cnt);
  // Quantized row in the low bits, upper bits zero
  assign spad_wdata_o = pick_qa ? spad_word_t'(qa_buf) : spad_word_t'(qb_buf);

  always_ff @(posedge clk) begin
    if (a_out_valid && !qa_buf_valid) qa_buf <= a_out_data;
    if (b_out_valid && !qb_buf_valid) qb_buf <= b_out_data;
  end

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      {qa_buf_valid, qb_buf_valid, rr_q} <= 3'b000;
      {a_sent, b_sent, qa_cnt, qb_cnt}   <= '0;
    end else if (go_exec) begin
      rr_q                             <= 1'b0;
      {a_sent, b_sent, qa_cnt, qb_cnt} <= '0;
    end else begin
      if (a_out_valid && !qa_buf_valid) qa_buf_valid <= 1'b1;
      else if (pick_qa) qa_buf_valid <= 1'b0;
      if (b_out_valid && !qb_buf_valid) qb_buf_valid <= 1'b1;
      else if (pick_qb) qb_buf_valid <= 1'b0;
      if (x_rd_en_o) a_sent <= a_sent + 1'b1;
      if (w_rd_en_o) b_sent <= b_sent + 1'b1;
      if (pick_qa) qa_cnt <= qa_cnt + 1'b1;
      if (pick_qb) qb_cnt <= qb_cnt + 1'b1;
      if (spad_wen_o) rr_q <= !rr_q;
    end
  end

endmodule

/* row_buffer.sv */
module row_buffer #(
  parameter type row_t = logic [63:0],
  parameter int  DEPTH = 4
) (
  input  logic              clk,
  input  logic              rstnn,
  input  logic              wr_en_i,
  input  row_t              wr_data_i,
  input  logic              rd_en_i,
  output row_t              rd_data_o,
  output qdq_pkg::row_idx_t count_o,
  output logic              full_o
);
  import qdq_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  row_t             mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  row_idx_t         count_q;
  logic             do_wr;
  logic             do_rd;

  // Writes are dropped while full, reads while empty
  assign do_wr     = wr_en_i && !full_o;
  assign do_rd     = rd_en_i && (count_q != '0);
  assign full_o    = (count_q == row_idx_t'(DEPTH));
  assign count_o   = count_q;
  assign rd_data_o = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* row_requantizer.sv */
module row_requantizer #(
  parameter int  LANES     = 4,
  parameter int  IN_W      = 16,
  parameter int  OUT_W     = 8,
  parameter type in_row_t  = logic [LANES*IN_W-1:0],
  parameter type out_row_t = logic [LANES*OUT_W-1:0]
) (
  input  logic           clk,
  input  logic           rstnn,
  input  qdq_pkg::dqsh_t shift_i,
  input  logic           in_valid_i,
  output logic           in_ready_o,
  input  in_row_t        in_data_i,
  output logic           out_valid_o,
  input  logic           out_ready_i,
  output out_row_t       out_data_o
);

  // Signed OUT_W limits, sign-extended to IN_W
  localparam logic signed [IN_W-1:0] SAT_MAX = {{(IN_W-OUT_W+1){1'b0}}, {(OUT_W-1){1'b1}}};
  localparam logic signed [IN_W-1:0] SAT_MIN = {{(IN_W-OUT_W+1){1'b1}}, {(OUT_W-1){1'b0}}};

  out_row_t sat_row;
  out_row_t data_q;
  logic     valid_q;

  // Per lane arithmetic shift, then clamp
  always_comb begin
    logic signed [IN_W-1:0] lane;
    logic signed [IN_W-1:0] shifted;
    sat_row = '0;
    for (int l = 0; l < LANES; l++) begin
      lane    = in_data_i[l*IN_W +: IN_W];
      shifted = lane >>> shift_i;
      if (shifted > SAT_MAX) begin
        sat_row[l*OUT_W +: OUT_W] = SAT_MAX[OUT_W-1:0];
      end else if (shifted < SAT_MIN) begin
        sat_row[l*OUT_W +: OUT_W] = SAT_MIN[OUT_W-1:0];
      end else begin
        sat_row[l*OUT_W +: OUT_W] = shifted[OUT_W-1:0];
      end
    end
  end

  // Stage advances when empty or drained this cycle
  assign in_ready_o  = !valid_q || out_ready_i;
  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= sat_row;
    end
  end

endmodule

/* scratchpad.sv */
`include "qdq_mlsu_cfg.svh"

module scratchpad (
  input  logic                clk,
  input  logic                rstnn,
  input  logic                wen_i,
  input  qdq_pkg::spad_addr_t waddr_i,
  input  qdq_pkg::spad_word_t wdata_i,
  input  logic                rd_en_i,
  input  qdq_pkg::spad_addr_t rd_addr_i,
  output logic                rd_valid_o,
  output qdq_pkg::spad_word_t rd_data_o,
  input  logic                ext_wen_i,
  input  logic                ext_ren_i,
  input  qdq_pkg::spad_addr_t ext_addr_i,
  input  qdq_pkg::spad_word_t ext_wdata_i,
  output logic                ext_rvalid_o,
  output qdq_pkg::spad_word_t ext_rdata_o
);
  import qdq_pkg::*;

  spad_word_t mem [`QDQ_SPAD_DEPTH];
  logic       ext_wr_ok;

  // Engine has priority on an address collision
  assign ext_wr_ok = ext_wen_i && !(wen_i && (waddr_i == ext_addr_i));

  always_ff @(posedge clk) begin
    if (ext_wr_ok) begin
      mem[ext_addr_i] <= ext_wdata_i;
    end
    if (wen_i) begin
      mem[waddr_i] <= wdata_i;
    end
    if (rd_en_i) begin
      rd_data_o <= mem[rd_addr_i];
    end
    if (ext_ren_i) begin
      ext_rdata_o <= mem[ext_addr_i];
    end
  end

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      rd_valid_o   <= 1'b0;
      ext_rvalid_o <= 1'b0;
    end else begin
      rd_valid_o   <= rd_en_i;
      ext_rvalid_o <= ext_ren_i;
    end
  end

endmodule

/* tb_qdq_mlsu.sv */
`include "qdq_mlsu_cfg.svh"

module tb_qdq_mlsu;
  import qdq_pkg::*;

  localparam int ROWS           = `QDQ_ROWS;
  localparam int NUM_ENTRIES    = 5;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 200;

  typedef struct packed {
    logic     q_start;
    logic     dq_start;
    qsh_t     qsh;
    dqsh_t    dqsh;
    logic     exp_finish;
    row_idx_t exp_rows;
  } entry_t;

  logic       clk, rstnn;
  logic       inst_fifo_rready_i, inst_fifo_rrequest_o;
  inst_t      inst_fifo_rdata_i;
  logic       x_row_valid_i, x_row_last_i, x_row_ready_o;
  logic       w_row_valid_i, w_row_last_i, w_row_ready_o;
  in_row_t    x_row_data_i, w_row_data_i;
  logic       o_row_valid_o, o_row_last_o, o_row_ready_i;
  out_row_t   o_row_data_o;
  logic       ext_wen_i, ext_ren_i, ext_rvalid_o;
  spad_addr_t ext_addr_i;
  spad_word_t ext_wdata_i, ext_rdata_o;
  logic       q_finish_o;

  entry_t     entries [NUM_ENTRIES];
  in_row_t    x_rows [ROWS];
  in_row_t    w_rows [ROWS];
  acc_row_t   acc_rows [ROWS];
  spad_word_t exp_qa [ROWS];
  spad_word_t exp_qb [ROWS];
  out_row_t   o_rows [$];
  logic       o_lasts [$];
  int         finish_count;
  int         cycle_count;
  int         ready_phase;

  qdq_mlsu_top dut (.*);

  always #10 clk = ~clk;

  // ==============================
  // Reference rules
  // ==============================
  function automatic longint shift_clamp(input longint value, input int shift, input int width);
    longint hi;
    longint lo;
    longint s;
    hi = (longint'(1) << (width - 1)) - 1;
    lo = -(longint'(1) << (width - 1));
    s  = value >>> shift;
    if (s > hi) return hi;
    if (s < lo) return lo;
    return s;
  endfunction

  function automatic q_row_t quant_row(input in_row_t row, input int shift);
    logic signed [`QDQ_IN_W-1:0] lane;
    longint                      v;
    q_row_t                      res;
    for (int l = 0; l < ROWS; l++) begin
      lane = row[l*`QDQ_IN_W +: `QDQ_IN_W];
      v    = shift_clamp(longint'(lane), shift, `QDQ_Q_W);
      res[l*`QDQ_Q_W +: `QDQ_Q_W] = v[`QDQ_Q_W-1:0];
    end
    return res;
  endfunction

  function automatic out_row_t dequant_row(input acc_row_t row, input int shift);
    logic signed [`QDQ_ACC_W-1:0] lane;
    longint                       v;
    out_row_t                     res;
    for (int l = 0; l < ROWS; l++) begin
      lane = row[l*`QDQ_ACC_W +: `QDQ_ACC_W];
      v    = shift_clamp(longint'(lane), shift, `QDQ_OUT_W);
      res[l*`QDQ_OUT_W +: `QDQ_OUT_W] = v[`QDQ_OUT_W-1:0];
    end
    return res;
  endfunction

  // ==============================
  // Checking helpers
  // ==============================
  task stop_run();
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    assert (got === exp) else begin
      $display("ERROR at time %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic read_word(input spad_addr_t addr, output spad_word_t data);
    next_cycle();
    ext_ren_i  = 1'b1;
    ext_addr_i = addr;
    next_cycle();
    ext_ren_i  = 1'b0;
    @(negedge clk);
    assert (ext_rvalid_o) else begin
      $display("Scratchpad read of address %0d returned no valid data", addr);
      stop_run();
    end
    data = ext_rdata_o;
  endtask

  // Monitors sample mid-cycle where outputs are settled
  always @(negedge clk) begin
    if (rstnn && o_row_valid_o && o_row_ready_i) begin
      o_rows.push_back(o_row_data_o);
      o_lasts.push_back(o_row_last_o);
    end
    if (rstnn && q_finish_o) finish_count++;
  end

  // Bound protocol checker
  always @(negedge clk) begin
    assert (dut.u_asserts.fail_count == 0) else begin
      $display("A protocol assertion on the DUT ports failed");
      stop_run();
    end
  end

  // Output ready drops every third cycle
  always @(posedge clk) begin
    #2;
    ready_phase   = (ready_phase + 1) % 3;
    o_row_ready_i = (ready_phase != 0);
  end

  always @(posedge clk) begin
    cycle_count++;
    assert (cycle_count < TIMEOUT_CYCLES) else begin
      $display("Timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
      stop_run();
    end
  end

  // ==============================
  // One table entry
  // ==============================
  task automatic run_entry(input entry_t ent);
    spad_word_t word;
    for (int r = 0; r < ROWS; r++) begin
      acc_rows[r] = {$urandom(), $urandom(), $urandom(), $urandom()};
      x_rows[r]   = {$urandom(), $urandom()};
      w_rows[r]   = {$urandom(), $urandom()};
      next_cycle();
      ext_wen_i   = 1'b1;
      ext_addr_i  = spad_addr_t'(`QDQ_ACC_BASE + r);
      ext_wdata_i = spad_word_t'(acc_rows[r]);
    end
    next_cycle();
    ext_wen_i    = 1'b0;
    finish_count = 0;
    o_rows.delete();
    o_lasts.delete();

    // Offer the instruction until the engine takes it
    inst_fifo_rready_i = 1'b1;
    inst_fifo_rdata_i  = {ent.q_start, ent.dq_start, ent.qsh, ent.dqsh};
    @(negedge clk);
    while (!inst_fifo_rrequest_o) @(negedge clk);
    next_cycle();
    inst_fifo_rready_i = 1'b0;

    if (ent.q_start) begin
      for (int r = 0; r < ROWS; r++) begin
        x_row_valid_i = 1'b1;
        x_row_data_i  = x_rows[r];
        x_row_last_i  = (r == ROWS - 1);
        w_row_valid_i = 1'b1;
        w_row_data_i  = w_rows[r];
        w_row_last_i  = (r == ROWS - 1);
        @(negedge clk);
        while (!(x_row_ready_o && w_row_ready_o)) @(negedge clk);
        next_cycle();
      end
      {x_row_valid_i, x_row_last_i, w_row_valid_i, w_row_last_i} = 4'b0000;
      // Both buffers hold ROWS rows until the engine starts reading
      @(negedge clk);
      check_value("x_row_ready_o while full", x_row_ready_o, 1'b0);
      check_value("w_row_ready_o while full", w_row_ready_o, 1'b0);
    end

    @(negedge clk);
    while (!inst_fifo_rrequest_o) @(negedge clk);
    while (o_rows.size() < int'(ent.exp_rows)) @(negedge clk);
    repeat (4) @(negedge clk);

    check_value("q_finish_o pulse count", finish_count, ent.exp_finish);
    check_value("o_row count", o_rows.size(), ent.exp_rows);
    for (int r = 0; r < o_rows.size(); r++) begin
      check_value("o_row_data_o", o_rows[r], dequant_row(acc_rows[r], ent.dqsh));
      check_value("o_row_last_o", o_lasts[r], (r == ROWS - 1));
    end

    // Model only changes when quantize ran
    if (ent.q_start) begin
      for (int r = 0; r < ROWS; r++) begin
        exp_qa[r] = spad_word_t'(quant_row(x_rows[r], ent.qsh));
        exp_qb[r] = spad_word_t'(quant_row(w_rows[r], ent.qsh));
      end
    end
    for (int r = 0; r < ROWS; r++) begin
      read_word(spad_addr_t'(`QDQ_QA_BASE + r), word);
      check_value("scratchpad QA word", word, exp_qa[r]);
      read_word(spad_addr_t'(`QDQ_QB_BASE + r), word);
      check_value("scratchpad QB word", word, exp_qb[r]);
    end
  endtask

  initial begin
    clk                = 1'b0;
    rstnn              = 1'b0;
    inst_fifo_rready_i = 1'b0;
    inst_fifo_rdata_i  = '0;
    {x_row_valid_i, x_row_last_i, w_row_valid_i, w_row_last_i} = 4'b0000;
    x_row_data_i       = '0;
    w_row_data_i       = '0;
    o_row_ready_i      = 1'b0;
    ext_wen_i          = 1'b0;
    ext_ren_i          = 1'b0;
    ext_addr_i         = '0;
    ext_wdata_i        = '0;
    finish_count       = 0;
    cycle_count        = 0;
    ready_phase        = 0;
    void'($urandom(32'h81fcb1f7));

    // q, dq, qsh, dqsh, expected finish, expected O rows
    entries[0] = '{1'b1, 1'b1, 4'd0,  5'd0,  1'b1, 3'd4};
    entries[1] = '{1'b1, 1'b1, 4'd8,  5'd16, 1'b1, 3'd4};
    entries[2] = '{1'b0, 1'b1, 4'd3,  5'd31, 1'b0, 3'd4};
    entries[3] = '{1'b1, 1'b0, 4'd15, 5'd5,  1'b1, 3'd0};
    entries[4] = '{1'b1, 1'b1, 4'd4,  5'd12, 1'b1, 3'd4};

    repeat (8) @(posedge clk);
    #2;
    rstnn = 1'b1;
    @(negedge clk);
    check_value("o_row_valid_o after reset", o_row_valid_o, 1'b0);
    check_value("q_finish_o after reset", q_finish_o, 1'b0);
    check_value("inst_fifo_rrequest_o when idle", inst_fifo_rrequest_o, 1'b1);
    check_value("x_row_ready_o after reset", x_row_ready_o, 1'b1);
    check_value("w_row_ready_o after reset", w_row_ready_o, 1'b1);

    for (int e = 0; e < NUM_ENTRIES; e++) begin
      run_entry(entries[e]);
    end

    if (dut.u_asserts.fail_count != 0) begin
      $display("Protocol assertions on the DUT ports failed %0d times",
               dut.u_asserts.fail_count);
      stop_run();
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule
